//--- dma_pkg.sv
// DMA controller shared definitions
package dma_pkg;

  // ========================================
  // sizes
  // ========================================
  localparam int NCH        = 8;              // channel count
  localparam int CH_W       = $clog2(NCH);
  localparam int ADR_W      = 40;             // address and count width
  localparam int GAP_CYCLES = 10;             // idle cycles before next arbitration
  localparam int GAP_W      = $clog2(GAP_CYCLES);

  // ========================================
  // encodings
  // ========================================
  typedef enum logic [1:0] {
    MODE_SINGLE = 2'd0,
    MODE_BLOCK  = 2'd1,
    MODE_DEMAND = 2'd2                        // code 3 runs as single
  } dma_mode_e;

  // bit 0 = read cycle, bit 1 = write cycle
  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_READ  = 2'd1,
    OP_WRITE = 2'd2,
    OP_COPY  = 2'd3
  } dma_op_e;

  typedef enum logic [1:0] {
    STEP_HOLD = 2'd0,
    STEP_INC  = 2'd1,
    STEP_DEC  = 2'd2                          // code 3 holds
  } dma_step_e;

  typedef enum logic [2:0] {
    REG_SRC_BASE = 3'd0,
    REG_SRC_CURR = 3'd1,
    REG_DST_BASE = 3'd2,
    REG_DST_CURR = 3'd3,
    REG_CNT_BASE = 3'd4,
    REG_CNT_CURR = 3'd5,
    REG_FILL     = 3'd6,
    REG_CTRL     = 3'd7
  } dma_reg_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD,
    ST_RD_WAIT,
    ST_WR,
    ST_WR_WAIT,
    ST_GAP
  } dma_state_e;

  // ========================================
  // bundles
  // ========================================
  typedef struct packed {
    dma_mode_e  mode;
    dma_op_e    op;
    logic       en;
    logic       xen;                          // external request enable
    logic       autorl;
    logic [1:0] size;                         // byte step is 1 << size
    dma_step_e  src_step;
    dma_step_e  dst_step;
    logic       trig;                         // software trigger
  } chan_ctrl_t;

  typedef struct packed {
    chan_ctrl_t       ctrl;
    logic [ADR_W-1:0] src_base;
    logic [ADR_W-1:0] src_curr;
    logic [ADR_W-1:0] dst_base;
    logic [ADR_W-1:0] dst_curr;
    logic [ADR_W-1:0] cnt_base;
    logic [ADR_W-1:0] cnt_curr;
    logic [63:0]      fill;
  } chan_state_t;

  typedef struct packed {
    logic             valid;
    logic [CH_W-1:0]  ch;
    logic [ADR_W-1:0] src_curr;
    logic [ADR_W-1:0] dst_curr;
    logic [ADR_W-1:0] cnt;
  } chan_update_t;

  typedef struct packed {
    logic             rd;
    logic             wr;
    logic [1:0]       size;
    logic [ADR_W-1:0] adr;
    logic [63:0]      wdat;
  } mem_req_t;

  localparam chan_ctrl_t CTRL_RST = '{
    mode:     MODE_SINGLE,
    op:       OP_COPY,
    en:       1'b0,
    xen:      1'b0,
    autorl:   1'b0,
    size:     2'd0,
    src_step: STEP_INC,
    dst_step: STEP_INC,
    trig:     1'b0
  };

endpackage

//--- dma_regfile.sv
// DMA channel register file
`timescale 1ns/10ps
module dma_regfile (
  input  logic                     clk64,
  input  logic                     rst,
  input  logic                     cs_i,
  input  logic                     we_i,
  input  logic [7:0]               sel_i,
  input  logic [8:0]               adr_i,
  input  logic [63:0]              dat_i,
  output logic [63:0]              dat_o,
  input  logic                     trig_clr_i,
  input  logic [dma_pkg::CH_W-1:0] trig_ch_i,
  input  dma_pkg::chan_update_t    upd_i,
  output dma_pkg::chan_state_t     chans_o [dma_pkg::NCH]
);
  import dma_pkg::*;

  logic [CH_W-1:0] ch_sel;
  dma_reg_e        reg_sel;
  logic            wr_en;
  chan_state_t     rd_chan;
  logic [63:0]     ctrl_word;

  assign ch_sel  = adr_i[8:6];
  assign reg_sel = dma_reg_e'(adr_i[5:3]);
  assign wr_en   = cs_i & we_i;
  assign rd_chan = chans_o[ch_sel];

  // ========================================
  // register writes
  // ========================================
  always_ff @(posedge clk64) begin
    if (rst) begin
      for (int n = 0; n < NCH; n++) begin
        chans_o[n].ctrl <= CTRL_RST;         // addresses and fill keep their value
      end
    end else begin
      if (wr_en) begin
        case (reg_sel)
          REG_SRC_BASE: chans_o[ch_sel].src_base <= dat_i[ADR_W-1:0];
          REG_DST_BASE: chans_o[ch_sel].dst_base <= dat_i[ADR_W-1:0];
          REG_CNT_BASE: chans_o[ch_sel].cnt_base <= dat_i[ADR_W-1:0];
          REG_FILL:     chans_o[ch_sel].fill     <= dat_i;
          REG_CTRL: begin
            if (sel_i[0]) begin
              chans_o[ch_sel].ctrl.mode   <= dma_mode_e'(dat_i[1:0]);
              chans_o[ch_sel].ctrl.op     <= dma_op_e'(dat_i[3:2]);
              chans_o[ch_sel].ctrl.en     <= dat_i[4];
              chans_o[ch_sel].ctrl.xen    <= dat_i[5];
              chans_o[ch_sel].ctrl.autorl <= dat_i[6];
              // enable going high restarts the channel from its bases
              if (dat_i[4] && !rd_chan.ctrl.en) begin
                chans_o[ch_sel].src_curr <= rd_chan.src_base;
                chans_o[ch_sel].dst_curr <= rd_chan.dst_base;
                chans_o[ch_sel].cnt_curr <= '0;
              end
            end
            if (sel_i[1])
              chans_o[ch_sel].ctrl.size <= dat_i[9:8];
            if (sel_i[2]) begin
              chans_o[ch_sel].ctrl.src_step <= dma_step_e'(dat_i[17:16]);
              chans_o[ch_sel].ctrl.dst_step <= dma_step_e'(dat_i[19:18]);
            end
            if (sel_i[3])
              chans_o[ch_sel].ctrl.trig <= dat_i[31];
          end
          default: ;                          // current registers are read-only
        endcase
      end

      // engine side comes last so it wins over a cpu write
      if (upd_i.valid) begin
        chans_o[upd_i.ch].src_curr <= upd_i.src_curr;
        chans_o[upd_i.ch].dst_curr <= upd_i.dst_curr;
        chans_o[upd_i.ch].cnt_curr <= upd_i.cnt;
      end
      if (trig_clr_i)
        chans_o[trig_ch_i].ctrl.trig <= 1'b0;
    end
  end

  // ========================================
  // register reads
  // ========================================
  always_comb begin
    ctrl_word        = '0;
    ctrl_word[1:0]   = rd_chan.ctrl.mode;
    ctrl_word[3:2]   = rd_chan.ctrl.op;
    ctrl_word[4]     = rd_chan.ctrl.en;
    ctrl_word[5]     = rd_chan.ctrl.xen;
    ctrl_word[6]     = rd_chan.ctrl.autorl;
    ctrl_word[9:8]   = rd_chan.ctrl.size;
    ctrl_word[17:16] = rd_chan.ctrl.src_step;
    ctrl_word[19:18] = rd_chan.ctrl.dst_step;
    ctrl_word[31]    = rd_chan.ctrl.trig;
  end

  always_ff @(posedge clk64) begin
    case (reg_sel)
      REG_SRC_BASE: dat_o <= 64'(rd_chan.src_base);
      REG_SRC_CURR: dat_o <= 64'(rd_chan.src_curr);
      REG_DST_BASE: dat_o <= 64'(rd_chan.dst_base);
      REG_DST_CURR: dat_o <= 64'(rd_chan.dst_curr);
      REG_CNT_BASE: dat_o <= 64'(rd_chan.cnt_base);
      REG_CNT_CURR: dat_o <= 64'(rd_chan.cnt_curr);
      REG_FILL:     dat_o <= rd_chan.fill;
      default:      dat_o <= ctrl_word;      // control word
    endcase
  end

endmodule

//--- dma_arbiter.sv
// DMA channel arbiter
`timescale 1ns/10ps
module dma_arbiter (
  input  dma_pkg::chan_state_t     chans_i [dma_pkg::NCH],
  input  logic [dma_pkg::NCH-1:0]  xrq_i,
  output logic                     grant_valid_o,
  output logic [dma_pkg::CH_W-1:0] grant_ch_o
);
  import dma_pkg::*;

  logic [NCH-1:0] ready;

  // a channel is ready when enabled, not finished and asked for
  always_comb begin
    for (int n = 0; n < NCH; n++) begin
      ready[n] = chans_i[n].ctrl.en
              && (chans_i[n].cnt_curr < chans_i[n].cnt_base)
              && ((chans_i[n].ctrl.xen && xrq_i[n]) || chans_i[n].ctrl.trig);
    end
  end

  // fixed priority, lowest channel number wins
  always_comb begin
    grant_valid_o = |ready;
    grant_ch_o    = '0;
    for (int n = NCH - 1; n >= 0; n--) begin
      if (ready[n])
        grant_ch_o = CH_W'(n);
    end
  end

endmodule

//--- dma_engine.sv
// DMA transfer engine
`timescale 1ns/10ps
module dma_engine (
  input  logic                     clk64,
  input  logic                     rst,
  input  logic                     grant_valid_i,
  input  logic [dma_pkg::CH_W-1:0] grant_ch_i,
  input  dma_pkg::chan_state_t     chans_i [dma_pkg::NCH],
  input  logic [dma_pkg::NCH-1:0]  xrq_i,
  output dma_pkg::mem_req_t        mem_o,
  input  logic [63:0]              rd_dat_i,
  input  logic                     done_i,
  output logic [dma_pkg::NCH-1:0]  xack_o,
  output logic                     trig_clr_o,
  output logic [dma_pkg::CH_W-1:0] trig_ch_o,
  output dma_pkg::chan_update_t    upd_o
);
  import dma_pkg::*;

  dma_state_e       st;
  logic [CH_W-1:0]  ch_q;                    // channel being served
  logic [63:0]      data_q;                  // fill or read data
  logic [ADR_W-1:0] src_q;
  logic [ADR_W-1:0] dst_q;
  logic [ADR_W-1:0] cnt_q;
  logic [GAP_W-1:0] gap_q;

  chan_state_t      cur;
  chan_state_t      gnt;
  logic             has_rd;
  logic             has_wr;
  logic             gnt_rd;
  logic             gnt_wr;
  logic             item_done;
  logic             reload;
  logic             more;
  logic [ADR_W-1:0] byte_step;
  logic [ADR_W-1:0] nxt_cnt;
  logic [ADR_W-1:0] wb_src;
  logic [ADR_W-1:0] wb_dst;
  logic [ADR_W-1:0] wb_cnt;

  function automatic logic [ADR_W-1:0] step_adr(input logic [ADR_W-1:0] adr,
                                                input dma_step_e        dir,
                                                input logic [ADR_W-1:0] amt);
    case (dir)
      STEP_INC: return adr + amt;
      STEP_DEC: return adr - amt;
      default:  return adr;
    endcase
  endfunction

  assign cur        = chans_i[ch_q];
  assign gnt        = chans_i[grant_ch_i];
  assign has_rd     = cur.ctrl.op inside {OP_READ, OP_COPY};
  assign has_wr     = cur.ctrl.op inside {OP_WRITE, OP_COPY};
  assign gnt_rd     = gnt.ctrl.op inside {OP_READ, OP_COPY};
  assign gnt_wr     = gnt.ctrl.op inside {OP_WRITE, OP_COPY};
  assign trig_clr_o = (st == ST_IDLE) && grant_valid_i;
  assign trig_ch_o  = grant_ch_i;
  assign byte_step  = ADR_W'(1) << cur.ctrl.size;

  // final done of an item: write done, or read done with no write to follow
  assign item_done = done_i && ((st == ST_WR_WAIT) || (st == ST_RD_WAIT && !has_wr));

  // ========================================
  // progress after an item
  // ========================================
  always_comb begin
    wb_src  = has_rd ? step_adr(src_q, cur.ctrl.src_step, byte_step) : src_q;
    wb_dst  = has_wr ? step_adr(dst_q, cur.ctrl.dst_step, byte_step) : dst_q;
    nxt_cnt = cnt_q + ADR_W'(1);
    wb_cnt  = nxt_cnt;
    reload  = (nxt_cnt == cur.cnt_base) && cur.ctrl.autorl;
    case (cur.ctrl.mode)
      MODE_BLOCK:  more = nxt_cnt < cur.cnt_base;
      MODE_DEMAND: more = xrq_i[ch_q] && (nxt_cnt < cur.cnt_base);
      default:     more = 1'b0;                 // single
    endcase
    if (reload) begin
      wb_src = cur.src_base;
      wb_dst = cur.dst_base;
      wb_cnt = '0;
    end
  end

  // ========================================
  // state machine
  // ========================================
  always_ff @(posedge clk64) begin
    if (rst) begin
      st          <= ST_IDLE;
      mem_o.rd    <= 1'b0;
      mem_o.wr    <= 1'b0;
      xack_o      <= '0;
      upd_o.valid <= 1'b0;
      gap_q       <= '0;
    end else begin
      upd_o.valid <= 1'b0;
      case (st)
        ST_IDLE: begin
          if (grant_valid_i) begin
            ch_q   <= grant_ch_i;
            src_q  <= gnt.src_curr;
            dst_q  <= gnt.dst_curr;
            cnt_q  <= gnt.cnt_curr;
            data_q <= gnt.fill;
            if (gnt_rd)
              st <= ST_RD;
            else if (gnt_wr)
              st <= ST_WR;
            else begin                        // nothing to move
              st    <= ST_GAP;
              gap_q <= GAP_W'(GAP_CYCLES - 1);
            end
          end
        end
        ST_RD: begin
          mem_o.rd     <= 1'b1;
          mem_o.size   <= cur.ctrl.size;
          mem_o.adr    <= src_q;
          xack_o[ch_q] <= 1'b1;
          st           <= ST_RD_WAIT;
        end
        ST_RD_WAIT: begin
          if (done_i) begin
            mem_o.rd <= 1'b0;
            data_q   <= rd_dat_i;
            st       <= ST_WR;               // read-only is redirected below
          end
        end
        ST_WR: begin
          mem_o.wr     <= 1'b1;
          mem_o.size   <= cur.ctrl.size;
          mem_o.adr    <= dst_q;
          mem_o.wdat   <= data_q;
          xack_o[ch_q] <= 1'b1;
          st           <= ST_WR_WAIT;
        end
        ST_WR_WAIT: begin
          if (done_i)
            mem_o.wr <= 1'b0;
        end
        ST_GAP: begin
          if (gap_q == '0)
            st <= ST_IDLE;
          else
            gap_q <= gap_q - GAP_W'(1);
        end
        default: st <= ST_IDLE;
      endcase

      // item complete: write back, then continue the burst or rest
      if (item_done) begin
        xack_o[ch_q]   <= 1'b0;
        src_q          <= wb_src;
        dst_q          <= wb_dst;
        cnt_q          <= wb_cnt;
        upd_o.valid    <= 1'b1;
        upd_o.ch       <= ch_q;
        upd_o.src_curr <= wb_src;
        upd_o.dst_curr <= wb_dst;
        upd_o.cnt      <= wb_cnt;
        if (more)
          st <= has_rd ? ST_RD : ST_WR;
        else begin
          st    <= ST_GAP;
          gap_q <= GAP_W'(GAP_CYCLES - 1);
        end
      end
    end
  end

endmodule

//--- dma_top.sv
// DMA controller top level
`timescale 1ns/10ps
module dma_top (
  input  logic                     clk64,
  input  logic                     rst,
  input  logic                     cs_i,
  input  logic                     we_i,
  input  logic [7:0]               sel_i,
  input  logic [8:0]               adr_i,
  input  logic [63:0]              dat_i,
  output logic [63:0]              dat_o,
  input  logic [dma_pkg::NCH-1:0]  xrq_i,
  output logic [dma_pkg::NCH-1:0]  xack_o,
  output dma_pkg::mem_req_t        mem_o,
  input  logic [63:0]              rd_dat_i,
  input  logic                     done_i
);
  import dma_pkg::*;

  chan_state_t     chans [NCH];              // register file view of every channel
  chan_update_t    upd;
  logic            grant_valid;
  logic [CH_W-1:0] grant_ch;
  logic            trig_clr;
  logic [CH_W-1:0] trig_ch;

  dma_regfile u_regfile (
    .clk64      (clk64),
    .rst        (rst),
    .cs_i       (cs_i),
    .we_i       (we_i),
    .sel_i      (sel_i),
    .adr_i      (adr_i),
    .dat_i      (dat_i),
    .dat_o      (dat_o),
    .trig_clr_i (trig_clr),
    .trig_ch_i  (trig_ch),
    .upd_i      (upd),
    .chans_o    (chans)
  );

  dma_arbiter u_arbiter (
    .chans_i       (chans),
    .xrq_i         (xrq_i),
    .grant_valid_o (grant_valid),
    .grant_ch_o    (grant_ch)
  );

  dma_engine u_engine (
    .clk64         (clk64),
    .rst           (rst),
    .grant_valid_i (grant_valid),
    .grant_ch_i    (grant_ch),
    .chans_i       (chans),
    .xrq_i         (xrq_i),
    .mem_o         (mem_o),
    .rd_dat_i      (rd_dat_i),
    .done_i        (done_i),
    .xack_o        (xack_o),
    .trig_clr_o    (trig_clr),
    .trig_ch_o     (trig_ch),
    .upd_o         (upd)
  );

endmodule

//--- tb_mem_model.sv
// DMA testbench memory responder
`timescale 1ns/10ps
module tb_mem_model #(
  parameter logic [63:0] RD_KEY = 64'hc3a5_0f0f_5a5a_9669
) (
  input  logic                clk64,
  input  logic                rst,
  input  dma_pkg::mem_req_t   req_i,
  output logic [63:0]         rd_dat_o,
  output logic                done_o
);
  import dma_pkg::*;

  logic [31:0]      lfsr;
  logic [31:0]      lfsr_nxt;                // lfsr after one step
  logic             busy;
  logic [1:0]       lat;
  logic [ADR_W-1:0] wlog_adr [$];            // every write address, in order
  logic [63:0]      wlog_dat [$];

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic out_bit;
    out_bit = s[0];
    s = s >> 1;
    if (out_bit)
      s = s ^ 32'h8020_0003;
    return s;
  endfunction

  assign lfsr_nxt = lfsr_step(lfsr);

  always @(posedge clk64) begin
    if (rst) begin
      lfsr   <= 32'h1eca;
      busy   <= 1'b0;
      done_o <= 1'b0;
      lat    <= '0;
    end else begin
      done_o <= 1'b0;
      if (busy) begin
        if (lat == 2'd0) begin
          done_o   <= 1'b1;
          busy     <= 1'b0;
          rd_dat_o <= 64'(req_i.adr) ^ RD_KEY;  // read data is a function of the address
          if (req_i.wr) begin
            wlog_adr.push_back(req_i.adr);
            wlog_dat.push_back(req_i.wdat);
          end
        end else begin
          lat <= lat - 2'd1;
        end
      end else if ((req_i.rd || req_i.wr) && !done_o) begin
        busy <= 1'b1;
        lat  <= {lfsr[0], lfsr_nxt[0]};          // 1 to 4 cycles until done
        lfsr <= lfsr_step(lfsr_nxt);
      end
    end
  end

endmodule

//--- tb_dma.sv
// DMA controller testbench
`timescale 1ns/10ps
module tb_dma;
  import dma_pkg::*;

  localparam logic [63:0] RD_KEY = 64'hc3a5_0f0f_5a5a_9669;

  logic              clk64;
  logic              rst;
  logic              cs;
  logic              we;
  logic [7:0]        sel;
  logic [8:0]        adr;
  logic [63:0]       wdat;
  logic [63:0]       rdat;
  logic [NCH-1:0]    xrq;
  logic [NCH-1:0]    xack;
  mem_req_t          mem_req;
  logic [63:0]       rd_dat;
  logic              done;

  int                errors;
  int                wr_started;
  logic              wr_prev;
  mem_req_t          exp_q [$];              // expected writes in order
  mem_req_t          exp_all_q [$];          // same writes, kept for the memory log
  int                exp_ch_q [$];

  always #2 clk64 = ~clk64;

  dma_top uut (
    .clk64 (clk64), .rst (rst), .cs_i (cs), .we_i (we), .sel_i (sel), .adr_i (adr),
    .dat_i (wdat), .dat_o (rdat), .xrq_i (xrq), .xack_o (xack), .mem_o (mem_req),
    .rd_dat_i (rd_dat), .done_i (done)
  );

  tb_mem_model #(.RD_KEY(RD_KEY)) mem (
    .clk64 (clk64), .rst (rst), .req_i (mem_req), .rd_dat_o (rd_dat), .done_o (done)
  );

  // ========================================
  // reference model
  // ========================================
  function automatic logic [63:0] ctrl_word(input dma_mode_e m, input dma_op_e o,
      input logic en, input logic xen, input logic arl, input logic [1:0] sz,
      input dma_step_e ss, input dma_step_e ds, input logic trg);
    return 64'(m) | (64'(o) << 2) | (64'(en) << 4) | (64'(xen) << 5) | (64'(arl) << 6)
         | (64'(sz) << 8) | (64'(ss) << 16) | (64'(ds) << 18) | (64'(trg) << 31);
  endfunction

  function automatic logic [ADR_W-1:0] ref_adr(input logic [ADR_W-1:0] a,
      input dma_step_e d, input logic [1:0] sz);
    logic [ADR_W-1:0] amt;
    amt = (sz == 2'd0) ? 1 : (sz == 2'd1) ? 2 : (sz == 2'd2) ? 4 : 8;
    if (d == STEP_INC)
      return a + amt;
    else if (d == STEP_DEC)
      return a - amt;
    return a;
  endfunction

  // channel registers after one item
  function automatic chan_state_t ref_item(input chan_state_t c);
    if (c.ctrl.op[0])
      c.src_curr = ref_adr(c.src_curr, c.ctrl.src_step, c.ctrl.size);
    if (c.ctrl.op[1])
      c.dst_curr = ref_adr(c.dst_curr, c.ctrl.dst_step, c.ctrl.size);
    c.cnt_curr = c.cnt_curr + 1;
    if (c.cnt_curr == c.cnt_base && c.ctrl.autorl) begin
      c.src_curr = c.src_base;
      c.dst_curr = c.dst_base;
      c.cnt_curr = '0;
    end
    return c;
  endfunction

  // queue the writes of n items and return the final registers
  task automatic plan_items(input int ch, input int n, inout chan_state_t c);
    mem_req_t r;
    for (int i = 0; i < n; i++) begin
      r      = '0;
      r.size = c.ctrl.size;
      r.adr  = c.dst_curr;
      r.wdat = (c.ctrl.op == OP_COPY) ? (64'(c.src_curr) ^ RD_KEY) : c.fill;
      exp_q.push_back(r);
      exp_all_q.push_back(r);
      exp_ch_q.push_back(ch);
      c = ref_item(c);
    end
  endtask

  // ========================================
  // compare tasks
  // ========================================
  task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail t=%0t %s got %h exp %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_req(input string name, input mem_req_t got, input mem_req_t exp);
    if (got.adr !== exp.adr || got.wdat !== exp.wdat || got.size !== exp.size) begin
      $display("Fail t=%0t %s got %h/%h/%0d exp %h/%h/%0d", $time, name, got.adr, got.wdat,
               got.size, exp.adr, exp.wdat, exp.size);
      errors++;
    end
  endtask

  task automatic check_cnt(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Fail t=%0t %s got %0d exp %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  // write monitor, sampled at the falling edge where the bus is stable
  always @(negedge clk64) begin
    if (!rst && mem_req.wr && !wr_prev) begin
      wr_started++;
      if (exp_q.size() == 0) begin
        $display("unexpected write to %h at %0t", mem_req.adr, $time);
        errors++;
      end else begin
        check_req("mem_o", mem_req, exp_q.pop_front());
        check_cnt("xack_o", xack[exp_ch_q.pop_front()], 1);
      end
    end
    wr_prev = mem_req.wr;
  end

  // ========================================
  // cpu port and waits
  // ========================================
  task automatic cpu_write(input int ch, input dma_reg_e r, input logic [63:0] d,
      input logic [7:0] s);
    @(posedge clk64);
    #1;
    cs   = 1'b1;
    we   = 1'b1;
    sel  = s;
    adr  = {3'(ch), r, 3'b000};
    wdat = d;
    @(posedge clk64);
    #1;
    cs = 1'b0;
    we = 1'b0;
  endtask

  task automatic cpu_read(input int ch, input dma_reg_e r, output logic [63:0] v);
    @(posedge clk64);
    #1;
    cs  = 1'b1;
    adr = {3'(ch), r, 3'b000};
    @(posedge clk64);
    #1;
    v  = rdat;
    cs = 1'b0;
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s at %0t", what, $time);
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic wait_count(input int ch, input int exp);
    logic [63:0] v;
    int          n;
    n = 0;
    cpu_read(ch, REG_CNT_CURR, v);
    while (v != 64'(exp) && n < 200) begin
      cpu_read(ch, REG_CNT_CURR, v);
      n++;
    end
    if (v != 64'(exp))
      stop_on_timeout("channel count");
  endtask

  task automatic wait_writes(input int target);
    int n;
    n = 0;
    while (wr_started < target && n < 400) begin
      @(posedge clk64);
      n++;
    end
    if (wr_started < target)
      stop_on_timeout("write strobe");
    @(posedge clk64);
    #1;
  endtask

  task automatic load_chan(input int ch, input chan_state_t c);
    cpu_write(ch, REG_SRC_BASE, 64'(c.src_base), 8'hff);
    cpu_write(ch, REG_DST_BASE, 64'(c.dst_base), 8'hff);
    cpu_write(ch, REG_CNT_BASE, 64'(c.cnt_base), 8'hff);
    cpu_write(ch, REG_FILL, c.fill, 8'hff);
  endtask

  task automatic check_chan(input int ch, input chan_state_t c);
    logic [63:0] v;
    cpu_read(ch, REG_SRC_CURR, v);
    check_word("src_curr", v, 64'(c.src_curr));
    cpu_read(ch, REG_DST_CURR, v);
    check_word("dst_curr", v, 64'(c.dst_curr));
    cpu_read(ch, REG_CNT_CURR, v);
    check_word("cnt_curr", v, 64'(c.cnt_curr));
  endtask

  function automatic chan_state_t new_chan(input logic [ADR_W-1:0] s, input logic [ADR_W-1:0] d,
      input logic [ADR_W-1:0] n, input logic [63:0] f);
    chan_state_t c;
    c          = '0;
    c.ctrl     = CTRL_RST;
    c.src_base = s;
    c.src_curr = s;
    c.dst_base = d;
    c.dst_curr = d;
    c.cnt_base = n;
    c.fill     = f;
    return c;
  endfunction

  task automatic report(input int num, input string name, input int err0);
    if (errors == err0)
      $display("test %0d %s: ok", num, name);
    else
      $display("test %0d %s: %0d errors", num, name, errors - err0);
  endtask

  // ========================================
  // test sequence
  // ========================================
  initial begin
    chan_state_t c;
    chan_state_t c6;
    logic [63:0] v;
    logic [63:0] w;
    int          err0;
    int          base;

    clk64 = 1'b0;
    rst = 1'b1;
    cs = 1'b0;
    we = 1'b0;
    sel = '0;
    adr = '0;
    wdat = '0;
    xrq = '0;
    errors = 0;
    wr_started = 0;
    wr_prev = 1'b0;
    repeat (16) @(posedge clk64);
    #1;
    rst = 1'b0;

    // register access on channels 0 and 7
    err0 = errors;
    for (int k = 0; k < 2; k++) begin
      c = new_chan(40'h12_3456_7000 + 40'(k * 7), 40'h0a_bcde_f000 + 40'(k),
                   40'd9 + 40'(k), 64'h0123_4567_89ab_cdef ^ 64'(k));
      load_chan(k * 7, c);
      cpu_read(k * 7, REG_SRC_BASE, v);
      check_word("src_base", v, 64'(c.src_base));
      cpu_read(k * 7, REG_DST_BASE, v);
      check_word("dst_base", v, 64'(c.dst_base));
      cpu_read(k * 7, REG_CNT_BASE, v);
      check_word("cnt_base", v, 64'(c.cnt_base));
      cpu_read(k * 7, REG_FILL, v);
      check_word("fill", v, c.fill);
      w = ctrl_word(MODE_BLOCK, OP_COPY, 0, 0, 1, 2'd1, STEP_INC, STEP_DEC, 0);
      cpu_write(k * 7, REG_CTRL, w, 8'hff);
      cpu_write(k * 7, REG_CTRL,
                ctrl_word(MODE_DEMAND, OP_READ, 0, 1, 0, 2'd3, STEP_DEC, STEP_HOLD, 0), 8'h02);
      w[9:8] = 2'd3;                          // only the size lane was written
      cpu_read(k * 7, REG_CTRL, v);
      check_word("ctrl", v, w);
      w[4] = 1'b1;
      cpu_write(k * 7, REG_CTRL, w, 8'h01);
      cpu_read(k * 7, REG_CTRL, v);
      check_word("ctrl", v, w);
      cpu_write(k * 7, REG_SRC_CURR, 64'h55, 8'hff);
      check_chan(k * 7, c);
      w[4] = 1'b0;
      cpu_write(k * 7, REG_CTRL, w, 8'h01);
    end
    report(1, "register access", err0);

    // block copy on channel 3
    err0 = errors;
    c = new_chan(40'h1000, 40'h8000, 40'd4, '0);
    c.ctrl.mode = MODE_BLOCK;
    c.ctrl.size = 2'd3;
    load_chan(3, c);
    plan_items(3, 4, c);
    cpu_write(3, REG_CTRL, ctrl_word(MODE_BLOCK, OP_COPY, 1, 0, 0, 2'd3, STEP_INC, STEP_INC, 1),
              8'hff);
    wait_count(3, 4);
    check_chan(3, c);
    check_cnt("pending writes", exp_q.size(), 0);
    report(2, "block copy", err0);

    // write-only fill, single mode, destination decrement
    err0 = errors;
    c = new_chan(40'h0, 40'h4000, 40'd3, 64'hfeed_beef_0123_4567);
    c.ctrl.op = OP_WRITE;
    c.ctrl.size = 2'd2;
    c.ctrl.dst_step = STEP_DEC;
    load_chan(2, c);
    cpu_write(2, REG_CTRL, ctrl_word(MODE_SINGLE, OP_WRITE, 1, 0, 0, 2'd2, STEP_INC, STEP_DEC, 0),
              8'hff);
    for (int k = 0; k < 2; k++) begin
      base = wr_started;
      plan_items(2, 1, c);
      cpu_write(2, REG_CTRL, 64'h8000_0000, 8'h08);
      wait_count(2, k + 1);
      check_cnt("writes per trigger", wr_started - base, 1);
    end
    check_chan(2, c);
    report(3, "fill single", err0);

    // demand mode on channel 5
    err0 = errors;
    c = new_chan(40'h2000, 40'h3000, 40'd8, '0);
    c.ctrl.mode = MODE_DEMAND;
    c.ctrl.xen = 1'b1;
    load_chan(5, c);
    cpu_write(5, REG_CTRL, ctrl_word(MODE_DEMAND, OP_COPY, 1, 1, 0, 2'd0, STEP_INC, STEP_INC, 0),
              8'hff);
    plan_items(5, 2, c);
    base = wr_started;
    xrq[5] = 1'b1;
    wait_writes(base + 2);
    xrq[5] = 1'b0;
    wait_count(5, 2);
    repeat (3 * GAP_CYCLES) @(posedge clk64);
    check_cnt("demand writes", wr_started - base, 2);
    check_chan(5, c);
    report(4, "demand", err0);

    // auto-reload and priority, channel 1 before channel 6
    err0 = errors;
    c = new_chan(40'h5000, 40'h6000, 40'd2, '0);
    c.ctrl.mode = MODE_BLOCK;
    c.ctrl.size = 2'd3;
    c.ctrl.autorl = 1'b1;
    c6 = new_chan(40'h7000, 40'h9000, 40'd2, '0);
    c6.ctrl.mode = MODE_BLOCK;
    c6.ctrl.size = 2'd3;
    load_chan(1, c);
    load_chan(6, c6);
    cpu_write(1, REG_CTRL, ctrl_word(MODE_BLOCK, OP_COPY, 1, 1, 1, 2'd3, STEP_INC, STEP_INC, 0),
              8'hff);
    cpu_write(6, REG_CTRL, ctrl_word(MODE_BLOCK, OP_COPY, 1, 1, 0, 2'd3, STEP_INC, STEP_INC, 0),
              8'hff);
    plan_items(1, 2, c);
    plan_items(6, 2, c6);
    base = wr_started;
    @(posedge clk64);
    #1;
    xrq = 8'h42;
    wait_writes(base + 2);
    xrq[1] = 1'b0;
    wait_count(6, 2);
    xrq[6] = 1'b0;
    check_chan(1, c);
    check_chan(6, c6);
    check_cnt("pending writes", exp_q.size(), 0);
    report(5, "reload and priority", err0);

    // every planned write reached the memory with its address and data
    check_cnt("logged writes", mem.wlog_adr.size(), exp_all_q.size());
    for (int i = 0; i < mem.wlog_adr.size() && i < exp_all_q.size(); i++) begin
      check_word("log adr", 64'(mem.wlog_adr[i]), 64'(exp_all_q[i].adr));
      check_word("log data", mem.wlog_dat[i], exp_all_q[i].wdat);
    end

    $display("checks done, %0d errors, %0d writes", errors, wr_started);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- dma.f
dma_pkg.sv
dma_regfile.sv
dma_arbiter.sv
dma_engine.sv
dma_top.sv
tb_mem_model.sv
tb_dma.sv

//--- Bender.yml
package:
  name: dma

sources:
  - files:
      - dma_pkg.sv
      - dma_regfile.sv
      - dma_arbiter.sv
      - dma_engine.sv
      - dma_top.sv
  - target: simulation
    files:
      - tb_mem_model.sv
      - tb_dma.sv
